/* src/lvda_pkg.sv */
package lvda_pkg;

    // pio bus
    localparam int PIO_ADDR_W = 9;
    typedef logic [PIO_ADDR_W-1:0] pio_addr_t;

    localparam int WORD_W = 14;
    typedef logic [WORD_W-1:0] word_t;

    // discrete inputs, bank 0 in the low word
    localparam int N_BANKS = 2;
    typedef logic [N_BANKS*WORD_W-1:0] disc_bank_t;

    // bit 0 is the countdown, bits 1..7 the external requests
    localparam int INT_W = 8;
    typedef logic [INT_W-1:0] int_mask_t;
    typedef logic [INT_W-2:0] ext_int_t;

    // mapped pio addresses
    localparam pio_addr_t ADDR_READ_BANK0 = 9'h010;
    localparam pio_addr_t ADDR_READ_BANK1 = 9'h011;
    localparam pio_addr_t ADDR_READ_INT   = 9'h012;
    localparam pio_addr_t ADDR_LOAD_COUNT = 9'h020;
    localparam pio_addr_t ADDR_CLEAR_INT  = 9'h021;

    // read source select
    typedef logic [1:0] read_sel_t;

    localparam read_sel_t SEL_BANK0 = 2'd0;
    localparam read_sel_t SEL_BANK1 = 2'd1;
    localparam read_sel_t SEL_INT   = 2'd2;

endpackage

/* src/bit_timer.sv */
module bit_timer #(
    parameter int BIT_CYCLES = 4
) (
    input  logic sim_clk,
    input  logic reset,
    output logic bit_tick
);

    localparam int CNT_W = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

    logic [CNT_W-1:0] cycle_cnt;
    logic             wrap;

    assign wrap = (cycle_cnt == CNT_W'(BIT_CYCLES - 1));

    // free running cycle counter, one tick per wrap
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            cycle_cnt <= '0;
            bit_tick  <= 1'b0;
        end else begin
            bit_tick <= wrap;
            if (wrap) begin
                cycle_cnt <= '0;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

endmodule

/* src/pio_decode.sv */
module pio_decode
    import lvda_pkg::*;
(
    input  logic      sim_clk,
    input  logic      reset,
    input  logic      pio_strobe,
    input  pio_addr_t pio_addr,
    input  word_t     pio_data,
    output logic      read_req,
    output read_sel_t read_sel,
    output logic      load_count,
    output logic      clear_int,
    output word_t     cmd_data
);

    logic      hit_read;
    logic      hit_load;
    logic      hit_clear;
    read_sel_t sel_next;

    // address match, unmapped addresses hit nothing
    always_comb begin
        hit_read  = 1'b0;
        hit_load  = 1'b0;
        hit_clear = 1'b0;
        sel_next  = SEL_BANK0;
        case (pio_addr)
            ADDR_READ_BANK0: begin
                hit_read = 1'b1;
                sel_next = SEL_BANK0;
            end
            ADDR_READ_BANK1: begin
                hit_read = 1'b1;
                sel_next = SEL_BANK1;
            end
            ADDR_READ_INT: begin
                hit_read = 1'b1;
                sel_next = SEL_INT;
            end
            ADDR_LOAD_COUNT: hit_load = 1'b1;
            ADDR_CLEAR_INT:  hit_clear = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            read_req   <= 1'b0;
            load_count <= 1'b0;
            clear_int  <= 1'b0;
        end else begin
            read_req   <= pio_strobe && hit_read;
            load_count <= pio_strobe && hit_load;
            clear_int  <= pio_strobe && hit_clear;
        end
    end

    // operand and select held until the next strobe
    always_ff @(posedge sim_clk) begin
        if (pio_strobe) begin
            cmd_data <= pio_data;
            read_sel <= sel_next;
        end
    end

endmodule

/* src/discrete_sampler.sv */
module discrete_sampler
    import lvda_pkg::*;
(
    input  logic       sim_clk,
    input  logic       reset,
    input  logic       bit_tick,
    input  logic       read_req,
    input  read_sel_t  read_sel,
    input  disc_bank_t din,
    input  int_mask_t  int_pending,
    output logic       data
);

    localparam int BCNT_W = $clog2(WORD_W);

    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        START,
        SHIFT
    } state_t;

    state_t            state;
    logic [BCNT_W-1:0] bit_cnt;
    word_t             shreg;
    word_t             sel_word;
    logic              capture;
    logic              shifting;

    always_comb begin
        case (read_sel)
            SEL_BANK0: sel_word = din[0 +: WORD_W];
            SEL_BANK1: sel_word = din[WORD_W +: WORD_W];
            default:   sel_word = word_t'(int_pending);
        endcase
    end

    // requests outside idle are dropped
    assign capture  = (state == IDLE) && read_req;
    assign shifting = bit_tick && ((state == START) || (state == SHIFT));

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            state   <= IDLE;
            bit_cnt <= '0;
            data    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (read_req) begin
                        state <= ARMED;
                    end
                end
                ARMED: begin
                    // wait for a bit boundary, then the start bit
                    if (bit_tick) begin
                        state <= START;
                        data  <= 1'b1;
                    end
                end
                START: begin
                    if (bit_tick) begin
                        state   <= SHIFT;
                        data    <= shreg[WORD_W-1];
                        bit_cnt <= '0;
                    end
                end
                SHIFT: begin
                    if (bit_tick) begin
                        if (bit_cnt == BCNT_W'(WORD_W - 1)) begin
                            state <= IDLE;
                            data  <= 1'b0;
                        end else begin
                            data    <= shreg[WORD_W-1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // msb first
    always_ff @(posedge sim_clk) begin
        if (capture) begin
            shreg <= sel_word;
        end else if (shifting) begin
            shreg <= {shreg[WORD_W-2:0], 1'b0};
        end
    end

endmodule

/* src/countdown_interrupt.sv */
module countdown_interrupt
    import lvda_pkg::*;
(
    input  logic      sim_clk,
    input  logic      reset,
    input  logic      bit_tick,
    input  logic      load_count,
    input  logic      clear_int,
    input  word_t     cmd_data,
    input  ext_int_t  ext_int,
    output int_mask_t int_pending,
    output logic      intc
);

    word_t     count;
    logic      expire;
    int_mask_t set_bits;
    int_mask_t clr_bits;

    // only the 1 -> 0 step interrupts, a load of 0 stays quiet
    assign expire = bit_tick && !load_count && (count == word_t'(1));

    assign set_bits = {ext_int, expire};
    assign clr_bits = clear_int ? cmd_data[INT_W-1:0] : '0;

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            count <= '0;
        end else if (load_count) begin
            count <= cmd_data;
        end else if (bit_tick && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // set wins over clear
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            int_pending <= '0;
        end else begin
            int_pending <= (int_pending & ~clr_bits) | set_bits;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            intc <= 1'b0;
        end else begin
            intc <= |int_pending;
        end
    end

endmodule

/* src/lvda.sv */
module lvda
    import lvda_pkg::*;
#(
    parameter int BIT_CYCLES = 4
) (
    input  logic       sim_clk,
    input  logic       reset,
    input  logic       pio_strobe,
    input  pio_addr_t  pio_addr,
    input  word_t      pio_data,
    input  disc_bank_t din,
    input  ext_int_t   ext_int,
    output logic       data,
    output logic       intc
);

    logic      bit_tick;
    logic      read_req;
    read_sel_t read_sel;
    logic      load_count;
    logic      clear_int;
    word_t     cmd_data;
    int_mask_t int_pending;

    bit_timer #(
        .BIT_CYCLES(BIT_CYCLES)
    ) u_bit_timer (
        .sim_clk (sim_clk),
        .reset   (reset),
        .bit_tick(bit_tick)
    );

    pio_decode u_pio_decode (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .pio_strobe(pio_strobe),
        .pio_addr  (pio_addr),
        .pio_data  (pio_data),
        .read_req  (read_req),
        .read_sel  (read_sel),
        .load_count(load_count),
        .clear_int (clear_int),
        .cmd_data  (cmd_data)
    );

    discrete_sampler u_discrete_sampler (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .bit_tick   (bit_tick),
        .read_req   (read_req),
        .read_sel   (read_sel),
        .din        (din),
        .int_pending(int_pending),
        .data       (data)
    );

    countdown_interrupt u_countdown_interrupt (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .bit_tick   (bit_tick),
        .load_count (load_count),
        .clear_int  (clear_int),
        .cmd_data   (cmd_data),
        .ext_int    (ext_int),
        .int_pending(int_pending),
        .intc       (intc)
    );

endmodule

/* sim/lvda_tb.sv */
module lvda_tb
    import lvda_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CYCLES     = 4;
    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 5;
    localparam int N_TESTS        = 11;
    localparam int MAX_COUNT      = 5;
    localparam int EXT_BIT        = 2;
    localparam int INTC_WAIT      = 8;
    localparam int FRAME_CYCLES   = 16 * BIT_CYCLES;
    localparam int TIMEOUT_CYCLES = N_TESTS * (FRAME_CYCLES + 8) + MAX_COUNT * BIT_CYCLES;

    typedef enum int {OP_READ, OP_LOAD, OP_CLEAR, OP_IRQ, OP_UNMAPPED, OP_BUSY} op_t;

    logic       sim_clk;
    logic       reset;
    logic       pio_strobe;
    pio_addr_t  pio_addr;
    word_t      pio_data;
    disc_bank_t din;
    ext_int_t   ext_int;
    logic       data;
    logic       intc;

    // stimulus table
    string     test_name [N_TESTS];
    op_t       test_op   [N_TESTS];
    pio_addr_t test_addr [N_TESTS];
    word_t     test_data [N_TESTS];
    word_t     test_exp  [N_TESTS];
    int        n_tests = 0;

    integer seed;
    word_t  bank0;
    word_t  bank1;
    int     errors = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycle_cnt;
    int     start_errors;
    logic   data_seen;
    logic   intc_seen;

    lvda #(
        .BIT_CYCLES(BIT_CYCLES)
    ) dut (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .pio_strobe(pio_strobe),
        .pio_addr  (pio_addr),
        .pio_data  (pio_data),
        .din       (din),
        .ext_int   (ext_int),
        .data      (data),
        .intc      (intc)
    );

    initial begin
        sim_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sim_clk = ~sim_clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge sim_clk);
            cycle_cnt++;
        end
        $display("ERROR timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic add_test(input string name, input op_t op, input pio_addr_t addr,
                            input word_t wdata, input word_t exp);
        test_name[n_tests] = name;
        test_op[n_tests]   = op;
        test_addr[n_tests] = addr;
        test_data[n_tests] = wdata;
        test_exp[n_tests]  = exp;
        n_tests++;
    endtask

    task automatic pio_write(input pio_addr_t addr, input word_t wdata);
        @(posedge sim_clk);
        #DRIVE_DELAY;
        pio_strobe = 1'b1;
        pio_addr   = addr;
        pio_data   = wdata;
        @(posedge sim_clk);
        #DRIVE_DELAY;
        pio_strobe = 1'b0;
    endtask

    task automatic wait_intc(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (intc !== level && n < max_cycles) begin
            @(negedge sim_clk);
            n++;
        end
    endtask

    task automatic wait_frame(input int max_cycles, output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < max_cycles && !seen; n++) begin
            @(negedge sim_clk);
            if (data === 1'b1) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic receive_word(output bit seen, output word_t word, output logic stop);
        int i;
        word = '0;
        stop = 1'b0;
        wait_frame(2 * BIT_CYCLES + 8, seen);
        if (seen) begin
            // detected half a cycle into the start bit
            repeat (BIT_CYCLES + BIT_CYCLES / 2) @(negedge sim_clk);
            word[WORD_W-1] = data;
            for (i = WORD_W - 2; i >= 0; i--) begin
                repeat (BIT_CYCLES) @(negedge sim_clk);
                word[i] = data;
            end
            // line back low after the last bit
            repeat (BIT_CYCLES) @(negedge sim_clk);
            stop = data;
        end
    endtask

    task automatic check_frame(input string name, input word_t exp, input bit seen,
                               input word_t word, input logic stop);
        if (seen) begin
            check_word(name, exp, word);
            check_bit(name, 1'b0, stop);
        end else begin
            $display("ERROR %s: no frame appeared on data", name);
            errors++;
        end
    endtask

    task automatic run_test(input int idx);
        bit    seen;
        bit    again;
        logic  stop;
        logic  level_seen;
        word_t word;
        int    low_cycles;
        case (test_op[idx])
            OP_READ: begin
                pio_write(test_addr[idx], test_data[idx]);
                receive_word(seen, word, stop);
                check_frame(test_name[idx], test_exp[idx], seen, word, stop);
            end
            OP_LOAD: begin
                pio_write(test_addr[idx], test_data[idx]);
                if (test_data[idx] == '0) begin
                    low_cycles = 10 * BIT_CYCLES;
                end else begin
                    low_cycles = (test_data[idx] - 1) * BIT_CYCLES;
                end
                level_seen = 1'b0;
                repeat (low_cycles) begin
                    @(negedge sim_clk);
                    level_seen = level_seen | intc;
                end
                check_bit(test_name[idx], 1'b0, level_seen);
                if (test_exp[idx][0]) begin
                    wait_intc(1'b1, 2 * BIT_CYCLES + 4);
                    check_bit(test_name[idx], 1'b1, intc);
                end
            end
            OP_CLEAR: begin
                pio_write(test_addr[idx], test_data[idx]);
                wait_intc(test_exp[idx][0], INTC_WAIT);
                check_bit(test_name[idx], test_exp[idx][0], intc);
            end
            OP_IRQ: begin
                @(posedge sim_clk);
                #DRIVE_DELAY;
                ext_int = ext_int_t'(1) << test_data[idx];
                @(posedge sim_clk);
                #DRIVE_DELAY;
                ext_int = '0;
                wait_intc(test_exp[idx][0], INTC_WAIT);
                check_bit(test_name[idx], test_exp[idx][0], intc);
            end
            OP_UNMAPPED: begin
                pio_write(test_addr[idx], test_data[idx]);
                wait_frame(2 * FRAME_CYCLES, seen);
                if (seen) begin
                    $display("ERROR %s: a frame appeared for an unmapped address",
                             test_name[idx]);
                    errors++;
                end
                check_bit(test_name[idx], test_exp[idx][0], intc);
            end
            default: begin
                pio_write(test_addr[idx], test_data[idx]);
                fork
                    receive_word(seen, word, stop);
                    begin
                        // second read lands mid frame
                        wait (data === 1'b1);
                        repeat (3 * BIT_CYCLES) @(posedge sim_clk);
                        pio_write(ADDR_READ_BANK1, '0);
                    end
                join
                check_frame(test_name[idx], test_exp[idx], seen, word, stop);
                wait_frame(FRAME_CYCLES, again);
                if (again) begin
                    $display("ERROR %s: a second frame followed the dropped read",
                             test_name[idx]);
                    errors++;
                end
            end
        endcase
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("ok   %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    initial begin
        reset      = 1'b1;
        pio_strobe = 1'b0;
        pio_addr   = '0;
        pio_data   = '0;
        din        = '0;
        ext_int    = '0;

        seed  = 32'h21c6_f5b0;
        bank0 = word_t'($random(seed));
        bank1 = word_t'($random(seed));
        din   = {bank1, bank0};

        add_test("read_bank0", OP_READ, ADDR_READ_BANK0, '0, bank0);
        add_test("read_bank1", OP_READ, ADDR_READ_BANK1, '0, bank1);
        add_test("ext_irq", OP_IRQ, '0, word_t'(EXT_BIT), 1);
        add_test("read_int_ext", OP_READ, ADDR_READ_INT, '0, word_t'(1) << (EXT_BIT + 1));
        add_test("clear_ext", OP_CLEAR, ADDR_CLEAR_INT, word_t'(1) << (EXT_BIT + 1), 0);
        add_test("load_count_5", OP_LOAD, ADDR_LOAD_COUNT, word_t'(MAX_COUNT), 1);
        add_test("read_int_count", OP_READ, ADDR_READ_INT, '0, 14'h0001);
        add_test("clear_count", OP_CLEAR, ADDR_CLEAR_INT, 14'h0001, 0);
        add_test("load_count_0", OP_LOAD, ADDR_LOAD_COUNT, 14'd0, 0);
        // nonzero operand, taken as a load it would raise intc
        add_test("unmapped", OP_UNMAPPED, 9'h1ff, 14'd3, 0);
        add_test("busy_read", OP_BUSY, ADDR_READ_BANK0, '0, bank0);

        repeat (5) @(posedge sim_clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // both outputs quiet after reset
        start_errors = errors;
        data_seen    = 1'b0;
        intc_seen    = 1'b0;
        repeat (20) begin
            @(negedge sim_clk);
            data_seen = data_seen | data;
            intc_seen = intc_seen | intc;
        end
        check_bit("reset_data", 1'b0, data_seen);
        check_bit("reset_intc", 1'b0, intc_seen);
        finish_test("reset", start_errors);

        for (int i = 0; i < n_tests; i++) begin
            start_errors = errors;
            run_test(i);
            finish_test(test_name[i], start_errors);
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/lvda_pkg.sv
src/bit_timer.sv
src/pio_decode.sv
src/discrete_sampler.sv
src/countdown_interrupt.sv
src/lvda.sv
sim/lvda_tb.sv
